// File: clint/clint_bus_slave.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CLINT bus slave
// AXI-lite style read/write slave, one access in flight,
// decodes the register map into a one-cycle select strobe
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "clint_defs.svh"
`timescale 1ns/10ps
`default_nettype none

module clint_bus_slave import clint_pkg::*; (
	input  wire logic                     clock,
	input  wire logic                     rstn,
	input  wire logic                     ar_valid_i,
	output logic                          ar_ready_o,
	input  wire clint_ar_t                ar_i,
	output logic                          r_valid_o,
	input  wire logic                     r_ready_i,
	output clint_r_t                      r_o,
	input  wire logic                     aw_valid_i,
	output logic                          aw_ready_o,
	input  wire clint_aw_t                aw_i,
	output logic                          b_valid_o,
	input  wire logic                     b_ready_i,
	output resp_t                         b_resp_o,
	output reg_sel_t                      sel_o,
	input  wire logic [`CLINT_DATA_W-1:0] rd_data_i
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_RD_ACC,
		ST_RD_DATA,
		ST_WR_ACC,
		ST_WR_RESP
	} state_t;

	state_t   state_q, state_d;
	reg_sel_t sel_q, sel_d, dec;
	logic     hit, err_q, ar_fire, aw_fire;
	clint_r_t r_q;
	resp_t    b_resp_q;

	function automatic reg_sel_t decode(input logic [`CLINT_ADDR_W-1:0] addr);
		reg_sel_t                 s;
		logic [`CLINT_ADDR_W-1:0] off_msip;
		logic [`CLINT_ADDR_W-1:0] off_cmp;
		s = '0;
		off_msip = addr - `CLINT_MSIP_BASE;
		off_cmp = addr - `CLINT_MTIMECMP_BASE;
		// only word aligned accesses hit a register
		if (addr[1:0] == 2'b00) begin
			if (off_msip < 4 * `CLINT_NUM_HARTS) begin
				s.hart = off_msip[2 +: `CLINT_HART_W];
				s.tgt.msip = 1'b1;
			end else if (off_cmp < 8 * `CLINT_NUM_HARTS) begin
				s.hart = off_cmp[3 +: `CLINT_HART_W];
				s.tgt.cmp_hi = off_cmp[2];
				s.tgt.cmp_lo = ~off_cmp[2];
			end else if (addr == `CLINT_MTIME_BASE) begin
				s.tgt.mtime_lo = 1'b1;
			end else if (addr == `CLINT_MTIME_BASE + 4) begin
				s.tgt.mtime_hi = 1'b1;
			end
		end
		return s;
	endfunction

	// write wins when both arrive in the same idle cycle
	assign aw_ready_o = (state_q == ST_IDLE);
	assign ar_ready_o = (state_q == ST_IDLE) && !aw_valid_i;
	assign aw_fire = aw_valid_i && aw_ready_o;
	assign ar_fire = ar_valid_i && ar_ready_o;

	assign dec = decode(aw_valid_i ? aw_i.addr : ar_i.addr);
	assign hit = |dec.tgt;

	always_comb begin
		sel_d = '0;
		if (aw_fire) begin
			sel_d = dec;
			sel_d.we = hit;
			sel_d.wdata = aw_i.data;
		end else if (ar_fire) begin
			sel_d = dec;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (aw_valid_i)
					state_d = ST_WR_ACC;
				else if (ar_valid_i)
					state_d = ST_RD_ACC;
			end
			ST_RD_ACC:  state_d = ST_RD_DATA;
			ST_RD_DATA: if (r_ready_i) state_d = ST_IDLE;
			ST_WR_ACC:  state_d = ST_WR_RESP;
			ST_WR_RESP: if (b_ready_i) state_d = ST_IDLE;
			default:    state_d = ST_IDLE;
		endcase
	end

	// sel is cleared every cycle so it pulses for the access cycle
	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q <= ST_IDLE;
			sel_q <= '0;
		end else begin
			state_q <= state_d;
			sel_q <= sel_d;
		end
	end

	always_ff @(posedge clock) begin
		if (aw_fire || ar_fire)
			err_q <= ~hit;
		if (state_q == ST_RD_ACC) begin
			r_q.data <= err_q ? '0 : rd_data_i;
			r_q.resp <= err_q ? RESP_SLVERR : RESP_OKAY;
		end
		if (state_q == ST_WR_ACC)
			b_resp_q <= err_q ? RESP_SLVERR : RESP_OKAY;
	end

	assign sel_o = sel_q;
	assign r_o = r_q;
	assign r_valid_o = (state_q == ST_RD_DATA);
	assign b_valid_o = (state_q == ST_WR_RESP);
	assign b_resp_o = b_resp_q;

	// a stalled response keeps its valid and its payload
	a_r_hold: assert property (@(posedge clock) disable iff (!rstn)
		r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o));
	a_b_hold: assert property (@(posedge clock) disable iff (!rstn)
		b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_resp_o));
	a_we_pulse: assert property (@(posedge clock) disable iff (!rstn)
		sel_o.we |=> !sel_o.we);

endmodule

`default_nettype wire

// File: clint/clint_hart_timer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CLINT hart timer
// one hart's mtimecmp and msip, the registered timer
// compare and the read-back word for this hart
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "clint_defs.svh"
`timescale 1ns/10ps
`default_nettype none

module clint_hart_timer import clint_pkg::*; (
	input  wire logic                     clock,
	input  wire logic                     rstn,
	input  wire hart_idx_t                hart_id_i,
	input  wire reg_sel_t                 sel_i,
	input  wire logic [63:0]              mtime_i,
	output logic                          mtip_o,
	output logic                          msip_o,
	output logic [`CLINT_DATA_W-1:0]      rdata_o
);

	logic [63:0] mtimecmp_q;
	logic        msip_q, mtip_q;
	logic        hit;

	// only this hart reacts to a select carrying its index
	assign hit = (sel_i.hart == hart_id_i);

	always_ff @(posedge clock) begin
		if (!rstn) begin
			mtimecmp_q <= '1;
			msip_q <= 1'b0;
		end else if (sel_i.we && hit) begin
			if (sel_i.tgt.cmp_lo)
				mtimecmp_q[`CLINT_DATA_W-1:0] <= sel_i.wdata;
			if (sel_i.tgt.cmp_hi)
				mtimecmp_q[63:`CLINT_DATA_W] <= sel_i.wdata;
			if (sel_i.tgt.msip)
				msip_q <= sel_i.wdata[0];
		end
	end

	// compare is registered, so mtip lags mtime by a cycle
	always_ff @(posedge clock) begin
		if (!rstn)
			mtip_q <= 1'b0;
		else
			mtip_q <= (mtime_i >= mtimecmp_q);
	end

	assign mtip_o = mtip_q;
	assign msip_o = msip_q;

	always_comb begin
		rdata_o = '0;
		if (hit) begin
			if (sel_i.tgt.msip)
				rdata_o = {{(`CLINT_DATA_W-1){1'b0}}, msip_q};
			else if (sel_i.tgt.cmp_lo)
				rdata_o = mtimecmp_q[`CLINT_DATA_W-1:0];
			else if (sel_i.tgt.cmp_hi)
				rdata_o = mtimecmp_q[63:`CLINT_DATA_W];
		end
	end

	// msip moves only on a write aimed at this hart's msip word
	a_msip_hold: assert property (@(posedge clock) disable iff (!rstn)
		!(sel_i.we && hit && sel_i.tgt.msip) |=> $stable(msip_o));

endmodule

`default_nettype wire

// File: clint/clint_irq_collect.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CLINT interrupt collector
// packs per-hart interrupt lines into vectors and merges
// the read words of the harts and mtime for the bus
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "clint_defs.svh"
`timescale 1ns/10ps
`default_nettype none

module clint_irq_collect import clint_pkg::*; (
	input  wire logic                        clock,
	input  wire logic                        rstn,
	input  wire reg_sel_t                    sel_i,
	input  wire logic [`CLINT_DATA_W-1:0]    mtime_rd_i,
	input  wire logic                        hart_mtip_i [`CLINT_NUM_HARTS],
	input  wire logic                        hart_msip_i [`CLINT_NUM_HARTS],
	input  wire logic [`CLINT_DATA_W-1:0]    hart_rdata_i [`CLINT_NUM_HARTS],
	output logic [`CLINT_NUM_HARTS-1:0]      mtip_o,
	output logic [`CLINT_NUM_HARTS-1:0]      msip_o,
	output logic [`CLINT_DATA_W-1:0]         rd_data_o
);

	logic [`CLINT_DATA_W-1:0]   hart_or;
	logic [`CLINT_NUM_HARTS-1:0] hart_nz;

	// unaddressed harts return zero, so an OR is enough
	always_comb begin
		hart_or = '0;
		for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
			mtip_o[h] = hart_mtip_i[h];
			msip_o[h] = hart_msip_i[h];
			hart_or = hart_or | hart_rdata_i[h];
			hart_nz[h] = |hart_rdata_i[h];
		end
	end

	assign rd_data_o = (sel_i.tgt.mtime_lo || sel_i.tgt.mtime_hi) ? mtime_rd_i : hart_or;

	// index compare in the harts must select at most one of them
	a_one_rdata: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(hart_nz));

endmodule

`default_nettype wire

// File: clint/clint_mtime.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CLINT machine time
// shared 64-bit mtime counter, advanced by the rtc tick,
// with word writes and word read-back
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "clint_defs.svh"
`timescale 1ns/10ps
`default_nettype none

module clint_mtime import clint_pkg::*; (
	input  wire logic                     clock,
	input  wire logic                     rstn,
	input  wire logic                     rtc_tick_i,
	input  wire reg_sel_t                 sel_i,
	output logic [63:0]                   mtime_o,
	output logic [`CLINT_DATA_W-1:0]      mtime_rd_o
);

	logic [63:0] mtime_q;
	logic        wr_lo, wr_hi;

	assign wr_lo = sel_i.we && sel_i.tgt.mtime_lo;
	assign wr_hi = sel_i.we && sel_i.tgt.mtime_hi;

	// a write to either half takes the place of that tick
	always_ff @(posedge clock) begin
		if (!rstn) begin
			mtime_q <= '0;
		end else if (wr_lo) begin
			mtime_q[`CLINT_DATA_W-1:0] <= sel_i.wdata;
		end else if (wr_hi) begin
			mtime_q[63:`CLINT_DATA_W] <= sel_i.wdata;
		end else if (rtc_tick_i) begin
			mtime_q <= mtime_q + 64'd1;
		end
	end

	assign mtime_o = mtime_q;

	// word for the read path, zero unless mtime is addressed
	always_comb begin
		if (sel_i.tgt.mtime_hi)
			mtime_rd_o = mtime_q[63:`CLINT_DATA_W];
		else if (sel_i.tgt.mtime_lo)
			mtime_rd_o = mtime_q[`CLINT_DATA_W-1:0];
		else
			mtime_rd_o = '0;
	end

endmodule

`default_nettype wire

// File: common/clint_defs.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CLINT configuration
// hart count, bus widths and register map offsets
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CLINT_DEFS_SVH
`define CLINT_DEFS_SVH

// number of harts served
`define CLINT_NUM_HARTS 4

// hart index width, at least one bit
`define CLINT_HART_W ($clog2(`CLINT_NUM_HARTS) > 0 ? $clog2(`CLINT_NUM_HARTS) : 1)

// bus widths
`define CLINT_ADDR_W 16
`define CLINT_DATA_W 32

// msip words, 4 bytes per hart
`define CLINT_MSIP_BASE 16'h0000
// mtimecmp pairs, 8 bytes per hart
`define CLINT_MTIMECMP_BASE 16'h4000
// mtime low word, high word follows at +4
`define CLINT_MTIME_BASE 16'hBFF8

`endif

// File: common/clint_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CLINT shared types
// bus channel payloads, response codes and the decoded
// register access passed from the slave to the timers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "clint_defs.svh"

package clint_pkg;

	typedef logic [`CLINT_HART_W-1:0] hart_idx_t;

	// AXI style response codes
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_t;

	typedef struct packed {
		logic [`CLINT_ADDR_W-1:0] addr;
	} clint_ar_t;

	// address and data travel together
	typedef struct packed {
		logic [`CLINT_ADDR_W-1:0] addr;
		logic [`CLINT_DATA_W-1:0] data;
	} clint_aw_t;

	// last is implied high
	typedef struct packed {
		logic [`CLINT_DATA_W-1:0] data;
		resp_t                    resp;
	} clint_r_t;

	// one-hot register target, all zero when idle or unmapped
	typedef struct packed {
		logic mtime_hi;
		logic mtime_lo;
		logic cmp_hi;
		logic cmp_lo;
		logic msip;
	} reg_tgt_t;

	typedef struct packed {
		hart_idx_t                hart;
		reg_tgt_t                 tgt;
		logic                     we;
		logic [`CLINT_DATA_W-1:0] wdata;
	} reg_sel_t;

endpackage

`default_nettype wire

// File: design/clint_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CLINT top level
// bus slave, shared mtime, per-hart timers and the
// interrupt collector for a multi-hart RISC-V system
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "clint_defs.svh"
`timescale 1ns/10ps
`default_nettype none

module clint_top import clint_pkg::*; (
	input  wire logic                        clock,
	input  wire logic                        rstn,
	input  wire logic                        rtc_tick_i,
	input  wire logic                        ar_valid_i,
	output logic                             ar_ready_o,
	input  wire clint_ar_t                   ar_i,
	output logic                             r_valid_o,
	input  wire logic                        r_ready_i,
	output clint_r_t                         r_o,
	input  wire logic                        aw_valid_i,
	output logic                             aw_ready_o,
	input  wire clint_aw_t                   aw_i,
	output logic                             b_valid_o,
	input  wire logic                        b_ready_i,
	output resp_t                            b_resp_o,
	output logic [`CLINT_NUM_HARTS-1:0]      mtip_o,
	output logic [`CLINT_NUM_HARTS-1:0]      msip_o
);

	reg_sel_t                 sel;
	logic [63:0]              mtime;
	logic [`CLINT_DATA_W-1:0] mtime_rd;
	logic [`CLINT_DATA_W-1:0] rd_data;
	logic                     hart_mtip [`CLINT_NUM_HARTS];
	logic                     hart_msip [`CLINT_NUM_HARTS];
	logic [`CLINT_DATA_W-1:0] hart_rdata [`CLINT_NUM_HARTS];

	clint_bus_slave u_bus_slave (
		.clock      (clock),
		.rstn       (rstn),
		.ar_valid_i (ar_valid_i),
		.ar_ready_o (ar_ready_o),
		.ar_i       (ar_i),
		.r_valid_o  (r_valid_o),
		.r_ready_i  (r_ready_i),
		.r_o        (r_o),
		.aw_valid_i (aw_valid_i),
		.aw_ready_o (aw_ready_o),
		.aw_i       (aw_i),
		.b_valid_o  (b_valid_o),
		.b_ready_i  (b_ready_i),
		.b_resp_o   (b_resp_o),
		.sel_o      (sel),
		.rd_data_i  (rd_data)
	);

	clint_mtime u_mtime (
		.clock      (clock),
		.rstn       (rstn),
		.rtc_tick_i (rtc_tick_i),
		.sel_i      (sel),
		.mtime_o    (mtime),
		.mtime_rd_o (mtime_rd)
	);

	// each unit learns its index from the loop variable
	for (genvar h = 0; h < `CLINT_NUM_HARTS; h++) begin : g_hart
		clint_hart_timer u_timer (
			.clock     (clock),
			.rstn      (rstn),
			.hart_id_i (hart_idx_t'(h)),
			.sel_i     (sel),
			.mtime_i   (mtime),
			.mtip_o    (hart_mtip[h]),
			.msip_o    (hart_msip[h]),
			.rdata_o   (hart_rdata[h])
		);
	end

	clint_irq_collect u_collect (
		.clock        (clock),
		.rstn         (rstn),
		.sel_i        (sel),
		.mtime_rd_i   (mtime_rd),
		.hart_mtip_i  (hart_mtip),
		.hart_msip_i  (hart_msip),
		.hart_rdata_i (hart_rdata),
		.mtip_o       (mtip_o),
		.msip_o       (msip_o),
		.rd_data_o    (rd_data)
	);

endmodule

`default_nettype wire

// File: filelist.f
+incdir+common
common/clint_pkg.sv
clint/clint_bus_slave.sv
clint/clint_mtime.sv
clint/clint_hart_timer.sv
clint/clint_irq_collect.sv
design/clint_top.sv
tests/tb_clock_gen.sv
tests/tb_clint.sv

// File: tests/clint_golden.txt
# name op addr data resp mtip msip   (all values hex, resp 0 okay, 2 slverr)
# op is read, write, tick with data as count, or irq checking mtip and msip
rst_mtime_lo read BFF8 00000000 0 0 0
rst_cmp3_hi read 401C FFFFFFFF 0 0 0
rst_msip1 read 0004 00000000 0 0 0
rst_irq irq 0000 00000000 0 0 0
tick_ten tick 0000 0000000A 0 0 0
tick_read read BFF8 0000000A 0 0 0
mtime_wr_lo write BFF8 FFFFFFFE 0 0 0
mtime_wr_hi write BFFC 00000005 0 0 0
mtime_rd_hi read BFFC 00000005 0 0 0
tick_carry tick 0000 00000003 0 0 0
carry_hi read BFFC 00000006 0 0 0
carry_lo read BFF8 00000001 0 0 0
cmp0_hi_low write 4004 00000000 0 0 0
cmp0_irq irq 0000 00000000 0 1 0
cmp0_hi_back write 4004 FFFFFFFF 0 0 0
cmp1_hi write 400C 00000006 0 0 0
cmp1_lo write 4008 00000001 0 0 0
cmp1_irq irq 0000 00000000 0 2 0
cmp1_clear write 4008 00000002 0 0 0
msip2_set write 0008 FFFFFFFF 0 0 0
msip2_irq irq 0000 00000000 0 0 4
msip2_rd read 0008 00000001 0 0 0
msip2_clr write 0008 00000000 0 0 0
bad_rd read 0010 00000000 2 0 0
bad_wr write 5000 12345678 2 0 0
bad_align write 4009 00000000 2 0 0
keep_cmp1 read 4008 00000002 0 0 0
keep_mtime read BFFC 00000006 0 0 0
final_irq irq 0000 00000000 0 0 0

// File: tests/tb_clint.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CLINT testbench
// replays golden bus and tick vectors against the CLINT
// with random ready back-pressure on read data and write response
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "clint_defs.svh"
`timescale 1ns/10ps
`default_nettype none

module tb_clint import clint_pkg::*; ();

	localparam int MAX_VEC = 64;

	logic                        clock, rstn, rtc_tick;
	logic                        ar_valid, ar_ready, r_valid, r_ready;
	logic                        aw_valid, aw_ready, b_valid, b_ready;
	clint_ar_t                   ar;
	clint_r_t                    r;
	clint_aw_t                   aw;
	resp_t                       b_resp;
	logic [`CLINT_NUM_HARTS-1:0] mtip, msip;

	// one golden line per entry
	string                       vec_name [MAX_VEC];
	string                       vec_op [MAX_VEC];
	logic [31:0]                 vec_addr [MAX_VEC];
	logic [31:0]                 vec_data [MAX_VEC];
	logic [1:0]                  vec_resp [MAX_VEC];
	logic [`CLINT_NUM_HARTS-1:0] vec_mtip [MAX_VEC];
	logic [`CLINT_NUM_HARTS-1:0] vec_msip [MAX_VEC];
	int                          nvec, limit, cycles;
	int unsigned                 seed;

	tb_clock_gen u_clock_gen (.clock_o(clock), .rstn_o(rstn));

	clint_top DUT (
		.clock(clock), .rstn(rstn), .rtc_tick_i(rtc_tick),
		.ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_i(ar),
		.r_valid_o(r_valid), .r_ready_i(r_ready), .r_o(r),
		.aw_valid_i(aw_valid), .aw_ready_o(aw_ready), .aw_i(aw),
		.b_valid_o(b_valid), .b_ready_i(b_ready), .b_resp_o(b_resp),
		.mtip_o(mtip), .msip_o(msip)
	);

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string test, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s %s expected %h actual %h", test, field, expected, actual);
			stop_with_failure("value mismatch against golden vector");
		end
	endtask

	// lines that do not parse into all seven columns are comments
	task automatic load_vectors();
		int                          fd, cnt;
		logic [8*160-1:0]            line;
		string                       name, op;
		logic [31:0]                 addr, data;
		logic [1:0]                  resp;
		logic [`CLINT_NUM_HARTS-1:0] mt, ms;
		fd = $fopen("tests/clint_golden.txt", "r");
		if (fd == 0)
			stop_with_failure("cannot open tests/clint_golden.txt");
		nvec = 0;
		limit = 50;
		while (!$feof(fd)) begin
			line = '0;
			if ($fgets(line, fd) != 0) begin
				cnt = $sscanf(line, "%s %s %h %h %h %h %h", name, op, addr, data, resp, mt, ms);
				if (cnt == 7) begin
					if (nvec >= MAX_VEC)
						stop_with_failure("too many vectors in golden file");
					vec_name[nvec] = name;
					vec_op[nvec] = op;
					vec_addr[nvec] = addr;
					vec_data[nvec] = data;
					vec_resp[nvec] = resp;
					vec_mtip[nvec] = mt;
					vec_msip[nvec] = ms;
					limit += 8;
					if (op == "tick")
						limit += data;
					nvec++;
				end
			end
		end
		$fclose(fd);
		if (nvec == 0)
			stop_with_failure("golden file holds no vectors");
	endtask

	task automatic do_write(input string test, input logic [31:0] addr,
			input logic [31:0] data, output resp_t resp);
		int dly;
		@(negedge clock);
		aw_valid = 1'b1;
		aw.addr = addr[`CLINT_ADDR_W-1:0];
		aw.data = data;
		while (!aw_ready) @(negedge clock);
		@(negedge clock);
		aw_valid = 1'b0;
		while (!b_valid) @(negedge clock);
		resp = b_resp;
		dly = $urandom % 4;
		repeat (dly) begin
			@(negedge clock);
			check_value(test, "b_valid held", 1, b_valid);
			check_value(test, "aw_ready in stall", 0, aw_ready);
		end
		b_ready = 1'b1;
		@(negedge clock);
		b_ready = 1'b0;
	endtask

	task automatic do_read(input string test, input logic [31:0] addr,
			output logic [31:0] data, output resp_t resp);
		int dly;
		@(negedge clock);
		ar_valid = 1'b1;
		ar.addr = addr[`CLINT_ADDR_W-1:0];
		while (!ar_ready) @(negedge clock);
		@(negedge clock);
		ar_valid = 1'b0;
		while (!r_valid) @(negedge clock);
		data = r.data;
		resp = r.resp;
		// data must stay put while the master stalls
		dly = $urandom % 4;
		repeat (dly) begin
			@(negedge clock);
			check_value(test, "r_valid held", 1, r_valid);
			check_value(test, "r_data held", data, r.data);
			check_value(test, "ar_ready in stall", 0, ar_ready);
		end
		r_ready = 1'b1;
		@(negedge clock);
		r_ready = 1'b0;
	endtask

	task automatic pulse_ticks(input int count);
		@(negedge clock);
		rtc_tick = 1'b1;
		repeat (count) @(negedge clock);
		rtc_tick = 1'b0;
	endtask

	task automatic run_vector(input int i);
		logic [31:0] got_data;
		resp_t       got_resp;
		if (vec_op[i] == "write") begin
			do_write(vec_name[i], vec_addr[i], vec_data[i], got_resp);
			check_value(vec_name[i], "b_resp", vec_resp[i], got_resp);
		end else if (vec_op[i] == "read") begin
			do_read(vec_name[i], vec_addr[i], got_data, got_resp);
			check_value(vec_name[i], "r_data", vec_data[i], got_data);
			check_value(vec_name[i], "r_resp", vec_resp[i], got_resp);
		end else if (vec_op[i] == "tick") begin
			pulse_ticks(vec_data[i]);
		end else if (vec_op[i] == "irq") begin
			// mtip is registered, give it time to settle
			repeat (2) @(negedge clock);
			check_value(vec_name[i], "mtip", vec_mtip[i], mtip);
			check_value(vec_name[i], "msip", vec_msip[i], msip);
		end else begin
			stop_with_failure("unknown operation in golden file");
		end
	endtask

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit)
			stop_with_failure("timeout, the vectors did not finish within the cycle limit");
	end

	initial begin
		rtc_tick = 1'b0;
		ar_valid = 1'b0;
		ar = '0;
		r_ready = 1'b0;
		aw_valid = 1'b0;
		aw = '0;
		b_ready = 1'b0;
		seed = 32'hbbb9;
		void'($urandom(seed));
		load_vectors();
		wait (rstn === 1'b1);
		for (int i = 0; i < nvec; i++)
			run_vector(i);
		@(negedge clock);
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset
// 40 ns clock, active low reset held for five cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clock_o,
	output logic rstn_o
);

	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 5;

	initial begin
		clock_o = 1'b0;
		forever #(HALF_PERIOD) clock_o = ~clock_o;
	end

	// released on a falling edge, away from the sampling edge
	initial begin
		rstn_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock_o);
		@(negedge clock_o);
		rstn_o = 1'b1;
	end

endmodule

`default_nettype wire
